/* source/scope_defines.svh */
/*
 * Scope plotter constants for display geometry, grid, colours and channel calibration
 */
`ifndef SCOPE_DEFINES_SVH
`define SCOPE_DEFINES_SVH

`define SCOPE_NCOL       160
`define SCOPE_LAST_ROW   120  // Rows 0..120 inclusive
`define SCOPE_HMRK_BASE  9'd121

// Grid line hit tests
`define SCOPE_GRID_COLS(c) ((c) == 8'd20 || (c) == 8'd50 || (c) == 8'd80 || \
                            (c) == 8'd110 || (c) == 8'd140)
`define SCOPE_GRID_ROWS(r) ((r) == 8'd30 || (r) == 8'd60 || (r) == 8'd90)

// 12 bit colours, blue-green-red nibbles
`define COLOR_BLACK    12'h000
`define COLOR_RED      12'h00F
`define COLOR_GREEN    12'h0F0
`define COLOR_YELLOW   12'h0FF
`define COLOR_BLUE     12'hF00
`define COLOR_FUCHSIA  12'hF0F
`define COLOR_AQUA     12'hFF0
`define COLOR_WHITE    12'hFFF

`define GRID_COLOR  `COLOR_GREEN
`define CH1_COLOR   `COLOR_RED
`define CH2_COLOR   `COLOR_BLUE
`define MRK_COLOR   `COLOR_AQUA
`define TRG_COLOR   `COLOR_YELLOW

// Calibration offsets per volt/div setting
`define CAL_CH1_SAMPLE_OFS(v) ((v) == 2'd0 ? 9'sd37 : (v) == 2'd1 ? -9'sd27 : \
                               (v) == 2'd2 ? -9'sd59 : -9'sd75)
`define CAL_CH2_SAMPLE_OFS(v) ((v) == 2'd0 ? 9'sd98 : (v) == 2'd1 ? 9'sd34 : \
                               (v) == 2'd2 ? 9'sd2 : -9'sd14)
`define CAL_CH1_TRIG_OFS(v)   ((v) == 2'd0 ? 9'sd50 : (v) == 2'd1 ? -9'sd20 : \
                               (v) == 2'd2 ? -9'sd55 : -9'sd73)
`define CAL_CH2_TRIG_OFS(v)   ((v) == 2'd0 ? 9'sd111 : (v) == 2'd1 ? 9'sd40 : \
                               (v) == 2'd2 ? 9'sd5 : -9'sd13)

`endif

/* source/scope_pkg.sv */
/*
 * Scope plotter shared types and state encodings
 */
package scope_pkg;

  typedef logic [7:0]  col_t;  // Display column
  typedef logic [8:0]  row_t;  // Display row, wraps modulo 512
  typedef logic [13:0] adc_t;  // Raw ADC word
  typedef logic [11:0] rgb_t;  // Pixel colour

  // Readout sequencing
  typedef enum logic [1:0] {
    FETCH_REQ,
    FETCH_RELEASE,
    FETCH_HOLD
  } fetch_state_t;

  // Column drawing
  typedef enum logic {
    WAIT_SAMPLES,
    DRAW_COLUMN
  } draw_state_t;

endpackage

/* source/sample_fetch.sv */
/*
 * Sample fetch, runs a four-phase readout on both ADC buffers for the current column
 */
module sample_fetch import scope_pkg::*; (
  input  logic       Clock,
  input  logic       Reset_n,
  input  col_t       col,
  input  logic       column_done,
  input  logic       adc1_tdiv,
  input  logic       adc2_tdiv,
  input  logic       adc1_rdo_ack,
  input  logic       adc2_rdo_ack,
  input  adc_t       adc1_rdo_q,
  input  adc_t       adc2_rdo_q,
  output logic [8:0] adc1_rdo_add,
  output logic [8:0] adc2_rdo_add,
  output logic       adc1_rdo_req,
  output logic       adc2_rdo_req,
  output adc_t       sample1,
  output adc_t       sample2,
  output logic       samples_ready
);

  fetch_state_t state;

  // Time/div doubling picks every odd word of the lower half
  function automatic logic [8:0] rdo_addr(col_t c, logic tdiv);
    return tdiv ? {1'b0, c[6:0], 1'b1} : {1'b0, c};
  endfunction

  always_ff @(posedge Clock or negedge Reset_n) begin
    if (!Reset_n) begin
      state         <= FETCH_REQ;
      adc1_rdo_req  <= 1'b0;
      adc2_rdo_req  <= 1'b0;
      adc1_rdo_add  <= '0;
      adc2_rdo_add  <= '0;
      samples_ready <= 1'b0;
    end else begin
      case (state)
        FETCH_REQ: begin
          // Both buffers idle before a new request
          if (!adc1_rdo_ack && !adc2_rdo_ack) begin
            adc1_rdo_add <= rdo_addr(col, adc1_tdiv);  // Held for the whole transfer
            adc2_rdo_add <= rdo_addr(col, adc2_tdiv);
            adc1_rdo_req <= 1'b1;
            adc2_rdo_req <= 1'b1;
            state        <= FETCH_RELEASE;
          end
        end
        FETCH_RELEASE: begin
          if (adc1_rdo_req && adc1_rdo_ack)
            adc1_rdo_req <= 1'b0;
          if (adc2_rdo_req && adc2_rdo_ack)
            adc2_rdo_req <= 1'b0;
          // Complete once each ack has fallen after its req
          if (!adc1_rdo_req && !adc2_rdo_req && !adc1_rdo_ack && !adc2_rdo_ack) begin
            samples_ready <= 1'b1;
            state         <= FETCH_HOLD;
          end
        end
        FETCH_HOLD: begin
          if (column_done) begin
            samples_ready <= 1'b0;
            state         <= FETCH_REQ;
          end
        end
        default: state <= FETCH_REQ;
      endcase
    end
  end

  // Sample capture on ack
  always_ff @(posedge Clock) begin
    if (state == FETCH_RELEASE && adc1_rdo_req && adc1_rdo_ack)
      sample1 <= adc1_rdo_q;
    if (state == FETCH_RELEASE && adc2_rdo_req && adc2_rdo_ack)
      sample2 <= adc2_rdo_q;
  end

endmodule

/* source/trace_scaler.sv */
/*
 * Trace scaler, maps a raw sample and trigger level to display rows for one channel
 */
`include "scope_defines.svh"

module trace_scaler import scope_pkg::*; #(
  parameter int CHANNEL = 1  // 1 or 2, picks the calibration set
) (
  input  adc_t       sample,
  input  adc_t       trg_lvl,
  input  logic [1:0] vdiv,
  input  logic [7:0] vshift,
  output row_t       trace_row,
  output row_t       trig_row
);

  logic signed [8:0] sample_ofs;
  logic signed [8:0] trig_ofs;

  // Volt/div sets the right shift, offset and vshift move the trace
  function automatic row_t scale(adc_t raw, logic [1:0] div, logic [7:0] shift,
                                 logic signed [8:0] ofs);
    adc_t shifted;
    shifted = raw >> (4'd6 + 4'(div));
    return row_t'({1'b0, shift}) + row_t'(ofs) - row_t'(shifted);
  endfunction

  always_comb begin
    if (CHANNEL == 1) begin
      sample_ofs = `CAL_CH1_SAMPLE_OFS(vdiv);
      trig_ofs   = `CAL_CH1_TRIG_OFS(vdiv);
    end else begin
      sample_ofs = `CAL_CH2_SAMPLE_OFS(vdiv);
      trig_ofs   = `CAL_CH2_TRIG_OFS(vdiv);
    end
  end

  assign trace_row = scale(sample, vdiv, vshift, sample_ofs);
  assign trig_row  = scale(trg_lvl, vdiv, vshift, trig_ofs);  // Same rule as the trace

endmodule

/* source/pixel_composer.sv */
/*
 * Pixel composer, steps columns and rows and picks each pixel colour by priority
 */
`include "scope_defines.svh"

module pixel_composer import scope_pkg::*; (
  input  logic       Clock,
  input  logic       Reset_n,
  input  logic       samples_ready,
  input  row_t       trace_row1,
  input  row_t       trace_row2,
  input  row_t       trig_row1,
  input  row_t       trig_row2,
  input  logic [8:0] vmrk1,
  input  logic [8:0] vmrk2,
  input  logic [8:0] hmrk1,
  input  logic [8:0] hmrk2,
  output col_t       col,
  output logic       column_done,
  output col_t       x,
  output logic [7:0] y,
  output logic       wr,
  output rgb_t       rgb,
  output logic       rdo_done
);

  draw_state_t state;
  logic [7:0]  row;
  logic        drawing;
  logic        last_row;
  row_t        row_ext;
  logic [8:0]  col_next;

  // Row 0 goes out in the same cycle samples_ready rises
  assign drawing  = (state == DRAW_COLUMN) || (state == WAIT_SAMPLES && samples_ready);
  assign last_row = (row == 8'(`SCOPE_LAST_ROW));
  assign row_ext  = {1'b0, row};
  assign col_next = {1'b0, col} + 9'd1;

  assign column_done = drawing && last_row;
  assign rdo_done    = column_done && (col == 8'(`SCOPE_NCOL - 1));  // End of frame
  assign wr = drawing;
  assign x  = col;
  assign y  = row;

  always_ff @(posedge Clock or negedge Reset_n) begin
    if (!Reset_n) begin
      state <= WAIT_SAMPLES;
      col   <= '0;
      row   <= '0;
    end else begin
      case (state)
        WAIT_SAMPLES: begin
          if (samples_ready) begin
            row   <= 8'd1;
            state <= DRAW_COLUMN;
          end
        end
        DRAW_COLUMN: begin
          if (last_row) begin
            row   <= '0;
            col   <= rdo_done ? '0 : col_next[7:0];  // Wrap after the last column
            state <= WAIT_SAMPLES;
          end else begin
            row <= row + 8'd1;
          end
        end
        default: state <= WAIT_SAMPLES;
      endcase
    end
  end

  // Colour priority, later tests win
  always_comb begin
    rgb = `COLOR_BLACK;
    if (`SCOPE_GRID_COLS(col) || `SCOPE_GRID_ROWS(row))
      rgb = `GRID_COLOR;
    if (row_ext == trace_row1)
      rgb = `CH1_COLOR;
    if (row_ext == trace_row2)
      rgb = `CH2_COLOR;  // Channel 2 drawn over channel 1
    if (col_next == vmrk1 || col_next == vmrk2 ||
        row_ext == `SCOPE_HMRK_BASE - hmrk1 || row_ext == `SCOPE_HMRK_BASE - hmrk2)
      rgb = `MRK_COLOR;
    // Trigger ticks at the left edge
    if (col < 8'd2 && (row_ext == trig_row1 || row_ext == trig_row2))
      rgb = `TRG_COLOR;
  end

endmodule

/* source/scope_plot.sv */
/*
 * Scope plotter top, two-channel analog view on a 160 by 121 display
 */
`include "scope_defines.svh"

module scope_plot import scope_pkg::*; (
  input  logic       Clock,
  input  logic       Reset_n,
  output col_t       x,
  output logic [7:0] y,
  output logic       wr,
  output rgb_t       rgb,
  input  logic [8:0] vmrk1,
  input  logic [8:0] vmrk2,
  input  logic [8:0] hmrk1,
  input  logic [8:0] hmrk2,
  output logic [8:0] adc1_rdo_add,
  output logic       adc1_rdo_req,
  input  logic       adc1_rdo_ack,
  input  adc_t       adc1_rdo_q,
  input  logic       adc1_tdiv,
  input  logic [1:0] adc1_vdiv,
  input  logic [7:0] adc1_vshift,
  input  adc_t       adc1_trg_lvl,
  output logic [8:0] adc2_rdo_add,
  output logic       adc2_rdo_req,
  input  logic       adc2_rdo_ack,
  input  adc_t       adc2_rdo_q,
  input  logic       adc2_tdiv,
  input  logic [1:0] adc2_vdiv,
  input  logic [7:0] adc2_vshift,
  input  adc_t       adc2_trg_lvl,
  output logic       rdo_done
);

  col_t col;
  logic column_done;
  logic samples_ready;
  adc_t sample1, sample2;
  row_t trace_row1, trace_row2;
  row_t trig_row1, trig_row2;

  sample_fetch u_fetch (
    .Clock, .Reset_n, .col, .column_done,
    .adc1_tdiv, .adc2_tdiv,
    .adc1_rdo_ack, .adc2_rdo_ack,
    .adc1_rdo_q, .adc2_rdo_q,
    .adc1_rdo_add, .adc2_rdo_add,
    .adc1_rdo_req, .adc2_rdo_req,
    .sample1, .sample2, .samples_ready
  );

  trace_scaler #(.CHANNEL(1)) u_scale1 (
    .sample(sample1), .trg_lvl(adc1_trg_lvl), .vdiv(adc1_vdiv), .vshift(adc1_vshift),
    .trace_row(trace_row1), .trig_row(trig_row1)
  );

  trace_scaler #(.CHANNEL(2)) u_scale2 (
    .sample(sample2), .trg_lvl(adc2_trg_lvl), .vdiv(adc2_vdiv), .vshift(adc2_vshift),
    .trace_row(trace_row2), .trig_row(trig_row2)
  );

  pixel_composer u_compose (
    .Clock, .Reset_n, .samples_ready,
    .trace_row1, .trace_row2, .trig_row1, .trig_row2,
    .vmrk1, .vmrk2, .hmrk1, .hmrk2,
    .col, .column_done, .x, .y, .wr, .rgb, .rdo_done
  );

endmodule

/* test/tb_scope_plot.sv */
/*
 * Scope plotter testbench, models both sample buffers and checks every written pixel
 */
`include "scope_defines.svh"

module tb_scope_plot import scope_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_ENTRIES   = 5;
  localparam int FRAME_TIMEOUT = 40000;  // Cycles per frame wait
  localparam logic [31:0] LCG_SEED = 32'h89f67916;

  typedef struct packed {
    logic [1:0] vdiv1;
    logic [1:0] vdiv2;
    logic [7:0] vshift1;
    logic [7:0] vshift2;
    logic       tdiv1;
    logic       tdiv2;
    adc_t       trg1;
    adc_t       trg2;
    logic [8:0] vmrk1;
    logic [8:0] vmrk2;
    logic [8:0] hmrk1;
    logic [8:0] hmrk2;
    logic [8:0] trig_row1;  // Expected trigger rows, worked out by hand
    logic [8:0] trig_row2;
  } entry_t;

  logic       Clock;
  logic       Reset_n;
  col_t       x;
  logic [7:0] y;
  logic       wr;
  rgb_t       rgb;
  logic       rdo_done;
  logic [8:0] vmrk1, vmrk2, hmrk1, hmrk2;
  logic [8:0] rdo_add [2];  // Index 0 is channel 1
  logic       rdo_req [2];
  logic       rdo_ack [2];
  adc_t       rdo_q [2];
  logic       tdiv [2];
  logic [1:0] vdiv [2];
  logic [7:0] vshift [2];
  adc_t       trg_lvl [2];

  entry_t      stim [NUM_ENTRIES];
  adc_t        mem [2][512];
  logic [31:0] dly_state;
  int          wait_cnt [2];
  logic        req_seen [2];
  logic [8:0]  held_add [2];
  int          exp_col, exp_row, cur, frames, failures;

  scope_plot dut0 (
    .Clock, .Reset_n, .x, .y, .wr, .rgb,
    .vmrk1, .vmrk2, .hmrk1, .hmrk2,
    .adc1_rdo_add(rdo_add[0]), .adc1_rdo_req(rdo_req[0]), .adc1_rdo_ack(rdo_ack[0]),
    .adc1_rdo_q(rdo_q[0]), .adc1_tdiv(tdiv[0]), .adc1_vdiv(vdiv[0]),
    .adc1_vshift(vshift[0]), .adc1_trg_lvl(trg_lvl[0]),
    .adc2_rdo_add(rdo_add[1]), .adc2_rdo_req(rdo_req[1]), .adc2_rdo_ack(rdo_ack[1]),
    .adc2_rdo_q(rdo_q[1]), .adc2_tdiv(tdiv[1]), .adc2_vdiv(vdiv[1]),
    .adc2_vshift(vshift[1]), .adc2_trg_lvl(trg_lvl[1]),
    .rdo_done
  );

  always #20 Clock = ~Clock;

  function automatic logic [31:0] lcg_next(logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Buffer word read for a column
  function automatic logic [8:0] fetch_addr(int c, logic td);
    return td ? 9'((c % 128) * 2 + 1) : 9'(c);
  endfunction

  function automatic int sample_ofs(int ch, logic [1:0] v);
    if (ch == 0)
      return int'(`CAL_CH1_SAMPLE_OFS(v));
    return int'(`CAL_CH2_SAMPLE_OFS(v));
  endfunction

  // Display row of a channel's sample for column c, modulo 512
  function automatic int trace_row(int ch, int c);
    adc_t raw;
    int   r;
    raw = mem[ch][fetch_addr(c, tdiv[ch])];
    r = int'(vshift[ch]) + sample_ofs(ch, vdiv[ch]) - int'(raw >> (6 + int'(vdiv[ch])));
    return r & 511;
  endfunction

  function automatic rgb_t expected_color(int c, int r);
    logic [7:0] c8;
    logic [7:0] r8;
    rgb_t       color;
    c8 = 8'(c);
    r8 = 8'(r);
    color = `COLOR_BLACK;
    if (`SCOPE_GRID_COLS(c8) || `SCOPE_GRID_ROWS(r8))
      color = `GRID_COLOR;
    if (r == trace_row(0, c))
      color = `CH1_COLOR;
    if (r == trace_row(1, c))
      color = `CH2_COLOR;
    if (c + 1 == int'(vmrk1) || c + 1 == int'(vmrk2) ||
        r == 121 - int'(hmrk1) || r == 121 - int'(hmrk2))
      color = `MRK_COLOR;
    // Ticks only at the left edge
    if (c < 2 && (r == int'(stim[cur].trig_row1) || r == int'(stim[cur].trig_row2)))
      color = `TRG_COLOR;
    return color;
  endfunction

  task automatic report_error(string msg);
    failures++;
    $display("FAILED at %0.1f ns: %s", $realtime, msg);
    $display("Test failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic apply_entry(int k);
    cur       = k;
    vdiv[0]   = stim[k].vdiv1;
    vdiv[1]   = stim[k].vdiv2;
    vshift[0] = stim[k].vshift1;
    vshift[1] = stim[k].vshift2;
    tdiv[0]   = stim[k].tdiv1;
    tdiv[1]   = stim[k].tdiv2;
    trg_lvl[0] = stim[k].trg1;
    trg_lvl[1] = stim[k].trg2;
    vmrk1 = stim[k].vmrk1;
    vmrk2 = stim[k].vmrk2;
    hmrk1 = stim[k].hmrk1;
    hmrk2 = stim[k].hmrk2;
  endtask

  task automatic wait_frame(int k);
    int n;
    n = 0;
    while (rdo_done !== 1'b1) begin
      @(negedge Clock);
      n++;
      if (n > FRAME_TIMEOUT) begin
        $display("Timeout: no end-of-frame pulse within %0d cycles in frame %0d", n, k);
        $display("Test failed");
        $fatal(1, "frame wait timed out");
      end
    end
  endtask

  // Buffer models and readout handshake checks, both channels
  always @(posedge Clock) begin
    #2;
    if (Reset_n) begin
      for (int ch = 0; ch < 2; ch++) begin
        if (rdo_req[ch] && !req_seen[ch]) begin
          assert (!rdo_ack[ch])
            else report_error($sformatf("ch%0d req rose while ack high", ch + 1));
          assert (rdo_add[ch] == fetch_addr(exp_col, tdiv[ch]))
            else report_error($sformatf("ch%0d address %0d, expected %0d", ch + 1,
                                        rdo_add[ch], fetch_addr(exp_col, tdiv[ch])));
        end else if (rdo_req[ch]) begin
          assert (rdo_add[ch] == held_add[ch])
            else report_error($sformatf("ch%0d address moved while req high", ch + 1));
        end
        req_seen[ch] = rdo_req[ch];
        held_add[ch] = rdo_add[ch];
        if (rdo_req[ch] && !rdo_ack[ch]) begin
          if (wait_cnt[ch] == 0) begin
            dly_state    = lcg_next(dly_state);
            wait_cnt[ch] = 1 + int'(dly_state[25:24]);  // 1 to 4 cycles
          end
          wait_cnt[ch]--;
          if (wait_cnt[ch] == 0) begin
            rdo_q[ch]   = mem[ch][rdo_add[ch]];
            rdo_ack[ch] = 1'b1;
          end
        end else if (!rdo_req[ch] && rdo_ack[ch]) begin
          rdo_ack[ch] = 1'b0;
        end
      end
    end
  end

  // Pixel checker
  always @(negedge Clock) begin
    rgb_t want;
    if (Reset_n) begin
      assert (rdo_done == (wr && exp_col == `SCOPE_NCOL - 1 && exp_row == `SCOPE_LAST_ROW))
        else report_error($sformatf("rdo_done %0b at column %0d row %0d",
                                    rdo_done, exp_col, exp_row));
      if (rdo_done)
        frames++;
      if (wr) begin
        want = expected_color(exp_col, exp_row);
        assert (int'(x) == exp_col && int'(y) == exp_row)
          else report_error($sformatf("pixel at x %0d y %0d, expected x %0d y %0d",
                                      x, y, exp_col, exp_row));
        assert (rgb == want)
          else report_error($sformatf("colour %03h at x %0d y %0d, expected %03h",
                                      rgb, x, y, want));
        if (exp_row == `SCOPE_LAST_ROW) begin
          exp_row = 0;
          exp_col = (exp_col + 1) % `SCOPE_NCOL;
        end else begin
          exp_row++;
        end
      end else begin
        // A column goes out in one unbroken burst
        assert (exp_row == 0)
          else report_error($sformatf("write strobe dropped at column %0d row %0d",
                                      exp_col, exp_row));
      end
    end
  end

  initial begin
    logic [31:0] s;
    Clock   = 1'b0;
    Reset_n = 1'b0;
    stim = '{
      '{2'd0, 2'd3, 8'd60, 8'd40, 1'b0, 1'b1, 14'h1000, 14'h0800,
        9'd10, 9'd155, 9'd5, 9'd100, 9'd46, 9'd23},
      '{2'd1, 2'd2, 8'd100, 8'd10, 1'b1, 1'b0, 14'h2000, 14'h1800,
        9'd1, 9'd160, 9'd1, 9'd121, 9'd16, 9'd503},   // Ch2 tick wraps off screen
      '{2'd2, 2'd1, 8'd150, 8'd80, 1'b0, 1'b0, 14'h3000, 14'h0400,
        9'd81, 9'd21, 9'd61, 9'd200, 9'd47, 9'd112},  // Markers on grid lines
      '{2'd3, 2'd0, 8'd180, 8'd0, 1'b1, 1'b1, 14'h3FFF, 14'h0000,
        9'd2, 9'd0, 9'd0, 9'd90, 9'd76, 9'd111},
      '{2'd3, 2'd3, 8'd100, 8'd39, 1'b0, 1'b1, 14'h0100, 14'h0400,
        9'd30, 9'd30, 9'd40, 9'd40, 9'd27, 9'd24}     // Both traces span rows 25 down
    };
    s = LCG_SEED;
    for (int a = 0; a < 1024; a++) begin
      s = lcg_next(s);
      mem[a / 512][a % 512] = s[29:16];
    end
    dly_state = s;
    for (int ch = 0; ch < 2; ch++) begin
      rdo_ack[ch]  = 1'b0;
      rdo_q[ch]    = '0;
      wait_cnt[ch] = 0;
      req_seen[ch] = 1'b0;
      held_add[ch] = '0;
    end
    exp_col  = 0;
    exp_row  = 0;
    frames   = 0;
    failures = 0;
    apply_entry(0);
    repeat (16) @(posedge Clock);
    #2 Reset_n = 1'b1;
    for (int k = 0; k < NUM_ENTRIES; k++) begin
      wait_frame(k);
      @(posedge Clock);
      #2;
      assert (frames == k + 1)
        else report_error($sformatf("%0d end-of-frame pulses, expected %0d", frames, k + 1));
      if (k + 1 < NUM_ENTRIES)
        apply_entry(k + 1);  // Takes effect from column 0 of the next frame
    end
    if (failures == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

/* flist.f */
+incdir+source
source/scope_pkg.sv
source/sample_fetch.sv
source/trace_scaler.sv
source/pixel_composer.sv
source/scope_plot.sv
test/tb_scope_plot.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the scope plotter testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
BUILD_LOG="$BUILD_DIR/build.log"
SIM_LOG="$BUILD_DIR/sim.log"

mkdir -p "$BUILD_DIR"
if [ $? -ne 0 ]; then
  echo "Cannot create $BUILD_DIR"
  exit 1
fi

verilator --binary --timing --assert -f flist.f --top-module tb_scope_plot \
  -Mdir "$BUILD_DIR/obj_dir" > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "Build failed"
  exit 1
fi

"./$BUILD_DIR/obj_dir/Vtb_scope_plot" > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"

if grep -q "Test failed" "$SIM_LOG"; then
  echo "Simulation reported a failure"
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "Simulator exited with status $sim_status"
  exit 1
fi
echo "Simulation passed"
exit 0
